// File: verilog.f
hw/bus_pkg.sv
hw/lane_steer.sv
hw/clint_timer.sv
hw/bus_arbiter.sv
hw/cpu_bus_top.sv
dv/bus_checker.sv
dv/bus_monitor.sv
dv/tb_top.sv

// File: Bender.yml
package:
  name: cpu_bus

sources:
  - hw/bus_pkg.sv
  - hw/lane_steer.sv
  - hw/clint_timer.sv
  - hw/bus_arbiter.sv
  - hw/cpu_bus_top.sv
  - target: test
    files:
      - dv/bus_checker.sv
      - dv/bus_monitor.sv
      - dv/tb_top.sv

// File: dv/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  localparam int N_FETCH = 80;
  localparam int N_LSU_OPS = 60;
  // a store op is followed by its read-back load
  localparam int MAX_REQ = N_FETCH + 2 * N_LSU_OPS;
  localparam int CYCLE_LIMIT = MAX_REQ * 12 + 100;

  logic clk = 1'b0;
  logic rst;
  logic ifu_arvalid_i, ifu_rvalid_o;
  logic [31:0] ifu_araddr_i, ifu_rdata_o;
  logic lsu_arvalid_i, lsu_rvalid_o, lsu_awvalid_i, lsu_wready_o;
  logic [31:0] lsu_araddr_i, lsu_rdata_o, lsu_awaddr_i, lsu_wdata_i;
  logic [3:0] lsu_rstrb_i, lsu_wstrb_i;
  logic [3:0] axi_awid_o, axi_arid_o;
  logic [7:0] axi_awlen_o, axi_arlen_o, axi_wstrb_o;
  logic [2:0] axi_awsize_o, axi_arsize_o;
  logic [1:0] axi_awburst_o, axi_arburst_o, axi_bresp_i, axi_rresp_i;
  logic [31:0] axi_awaddr_o, axi_araddr_o;
  logic [63:0] axi_wdata_o, axi_rdata_i;
  logic axi_awvalid_o, axi_awready_i, axi_wlast_o, axi_wvalid_o, axi_wready_i;
  logic axi_bvalid_i, axi_bready_o, axi_arvalid_o, axi_arready_i;
  logic axi_rvalid_i, axi_rready_o;

  logic [63:0] mem [0:255];
  logic [31:0] ifu_rng, lsu_rng, slv_rng, fill;
  logic [31:0] rd_addr, wr_addr;
  logic [1:0]  ar_wait, aw_wait, w_wait, r_wait, b_wait;
  logic        ar_fire, aw_fire, w_fire, r_fire, b_fire;
  logic        r_pend, b_pend, aw_got, w_got;
  logic        slv_rst;
  int          cycles = 0;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  always #50 clk = ~clk;

  cpu_bus_top i_dut (.*);

  bus_monitor i_monitor (
    .clk (clk), .rst (rst),
    .ifu_araddr_i (ifu_araddr_i), .ifu_rvalid_i (ifu_rvalid_o), .ifu_rdata_i (ifu_rdata_o),
    .lsu_araddr_i (lsu_araddr_i), .lsu_rstrb_i (lsu_rstrb_i),
    .lsu_rvalid_i (lsu_rvalid_o), .lsu_rdata_i (lsu_rdata_o),
    .lsu_awaddr_i (lsu_awaddr_i), .lsu_wdata_i (lsu_wdata_i),
    .lsu_wstrb_i (lsu_wstrb_i), .lsu_wready_i (lsu_wready_o),
    .axi_arvalid_i (axi_arvalid_o), .axi_arready_i (axi_arready_i),
    .axi_arsize_i (axi_arsize_o), .axi_awvalid_i (axi_awvalid_o),
    .axi_awready_i (axi_awready_i), .axi_awsize_i (axi_awsize_o),
    .axi_wvalid_i (axi_wvalid_o), .axi_wready_i (axi_wready_i), .axi_wstrb_i (axi_wstrb_o)
  );

  task automatic wait_gap(input logic [1:0] n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_fetches();
    repeat (N_FETCH)
    begin
      ifu_rng = xorshift(ifu_rng);
      wait_gap(ifu_rng[1:0]);
      ifu_araddr_i  = {21'd0, ifu_rng[18:10], 2'b00};
      ifu_arvalid_i = 1'b1;
      do @(posedge clk); while (!ifu_rvalid_o);
      #1;
      ifu_arvalid_i = 1'b0;
    end
  endtask

  task automatic do_load(input logic [31:0] addr, input logic [3:0] strb);
    lsu_araddr_i  = addr;
    lsu_rstrb_i   = strb;
    lsu_arvalid_i = 1'b1;
    do @(posedge clk); while (!lsu_rvalid_o);
    #1;
    lsu_arvalid_i = 1'b0;
  endtask

  task automatic do_store(input logic [31:0] addr, input logic [3:0] strb,
                          input logic [31:0] data);
    lsu_awaddr_i  = addr;
    lsu_wstrb_i   = strb;
    lsu_wdata_i   = data;
    lsu_awvalid_i = 1'b1;
    do @(posedge clk); while (!lsu_wready_o);
    #1;
    lsu_awvalid_i = 1'b0;
  endtask

  task automatic run_lsu();
    logic [31:0] addr;
    logic [3:0]  strb;
    int          span;
    repeat (N_LSU_OPS)
    begin
      lsu_rng = xorshift(lsu_rng);
      wait_gap(lsu_rng[1:0]);
      strb = (lsu_rng[6:5] == 2'd0) ? 4'h1 : (lsu_rng[6:5] == 2'd1) ? 4'h3 : 4'hf;
      // offsets that keep the access inside one word
      span = (strb == 4'h1) ? 4 : (strb == 4'h3) ? 3 : 1;
      addr = {21'd0, lsu_rng[20:12], 2'b00} + (int'(lsu_rng[9:8]) % span);
      case (lsu_rng[4:3])
        2'd0:    do_load(lsu_rng[5] ? bus_pkg::MTIME_ADDR_HI : bus_pkg::MTIME_ADDR, 4'hf);
        2'd3:    do_load(addr, strb);
        default:
        begin
          do_store(addr, strb, xorshift(lsu_rng ^ 32'h5a5a));
          do_load(addr, strb);
        end
      endcase
    end
  endtask

  // axi slave memory with random ready and response delays
  always @(posedge clk)
  begin
    slv_rst = rst;
    ar_fire = axi_arvalid_o & axi_arready_i;
    aw_fire = axi_awvalid_o & axi_awready_i;
    w_fire  = axi_wvalid_o & axi_wready_i;
    r_fire  = axi_rvalid_i & axi_rready_o;
    b_fire  = axi_bvalid_i & axi_bready_o;
    if (ar_fire)
      rd_addr = axi_araddr_o;
    if (aw_fire)
      wr_addr = axi_awaddr_o;
    if (w_fire)
    begin
      for (int k = 0; k < 8; k++)
      begin
        if (axi_wstrb_o[k])
          mem[wr_addr[10:3]][8 * k +: 8] = axi_wdata_o[8 * k +: 8];
      end
    end
    #1;
    if (slv_rst)
    begin
      {ar_wait, aw_wait, w_wait} = '0;
      {r_pend, b_pend, aw_got, w_got, axi_rvalid_i, axi_bvalid_i} = '0;
    end
    else
    begin
      slv_rng = xorshift(slv_rng);
      ar_wait = ar_fire ? slv_rng[1:0] : (ar_wait != 0) ? ar_wait - 2'd1 : ar_wait;
      aw_wait = aw_fire ? slv_rng[3:2] : (aw_wait != 0) ? aw_wait - 2'd1 : aw_wait;
      w_wait  = w_fire ? slv_rng[5:4] : (w_wait != 0) ? w_wait - 2'd1 : w_wait;
      if (r_fire)
        axi_rvalid_i = 1'b0;
      if (ar_fire)
      begin
        r_pend = 1'b1;
        r_wait = slv_rng[7:6];
      end
      else if (r_pend && r_wait != 0)
        r_wait = r_wait - 2'd1;
      else if (r_pend)
      begin
        r_pend       = 1'b0;
        axi_rvalid_i = 1'b1;
        axi_rdata_i  = mem[rd_addr[10:3]];
      end
      if (b_fire)
        axi_bvalid_i = 1'b0;
      aw_got = aw_got | aw_fire;
      w_got  = w_got | w_fire;
      if (aw_got && w_got)
      begin
        {aw_got, w_got} = 2'b00;
        b_pend = 1'b1;
        b_wait = slv_rng[9:8];
      end
      else if (b_pend && b_wait != 0)
        b_wait = b_wait - 2'd1;
      else if (b_pend)
      begin
        b_pend       = 1'b0;
        axi_bvalid_i = 1'b1;
      end
    end
    axi_arready_i = !slv_rst && ar_wait == 0;
    axi_awready_i = !slv_rst && aw_wait == 0;
    axi_wready_i  = !slv_rst && w_wait == 0;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout after %0d cycles with requests still open", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial
  begin
    rst = 1'b1;
    {ifu_arvalid_i, lsu_arvalid_i, lsu_awvalid_i} = '0;
    {ifu_araddr_i, lsu_araddr_i, lsu_awaddr_i, lsu_wdata_i} = '0;
    {lsu_rstrb_i, lsu_wstrb_i} = '0;
    {axi_arready_i, axi_awready_i, axi_wready_i, axi_rvalid_i, axi_bvalid_i} = '0;
    axi_rdata_i = '0;
    axi_rresp_i = bus_pkg::AXI_RESP_OKAY;
    axi_bresp_i = bus_pkg::AXI_RESP_OKAY;
    fill = 32'h8e57;
    for (int i = 0; i < 256; i++)
    begin
      fill = xorshift(fill);
      mem[i][63:32] = fill;
      fill = xorshift(fill);
      mem[i][31:0] = fill;
      i_monitor.shadow[i] = mem[i];
    end
    ifu_rng = xorshift(fill);
    lsu_rng = xorshift(ifu_rng);
    slv_rng = xorshift(lsu_rng);
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    fork
      run_fetches();
      run_lsu();
    join
    repeat (2) @(posedge clk);
    i_monitor.close_report(i_dut.i_checker.fail_cnt);
    if (i_monitor.errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// File: dv/bus_monitor.sv
`timescale 1ns/1ps

module bus_monitor (
  input logic        clk,
  input logic        rst,
  input logic [31:0] ifu_araddr_i,
  input logic        ifu_rvalid_i,
  input logic [31:0] ifu_rdata_i,
  input logic [31:0] lsu_araddr_i,
  input logic [3:0]  lsu_rstrb_i,
  input logic        lsu_rvalid_i,
  input logic [31:0] lsu_rdata_i,
  input logic [31:0] lsu_awaddr_i,
  input logic [31:0] lsu_wdata_i,
  input logic [3:0]  lsu_wstrb_i,
  input logic        lsu_wready_i,
  input logic        axi_arvalid_i,
  input logic        axi_arready_i,
  input logic [2:0]  axi_arsize_i,
  input logic        axi_awvalid_i,
  input logic        axi_awready_i,
  input logic [2:0]  axi_awsize_i,
  input logic        axi_wvalid_i,
  input logic        axi_wready_i,
  input logic [7:0]  axi_wstrb_i
);

  logic [63:0] shadow [0:255];
  logic [63:0] mtime;
  logic [2:0]  ar_size_q;
  logic [2:0]  aw_size_q;
  logic [7:0]  wstrb_q;
  logic [7:0]  exp_strb;
  logic [31:0] exp;
  bit          ok;
  int          ar_cnt = 0;
  int          aw_cnt = 0;
  int          fetches = 0;
  int          axi_loads = 0;
  int          stores = 0;
  int          tests = 0;
  int          passes = 0;
  int          errors = 0;

  function automatic int nbytes(input logic [3:0] strb);
    case (strb)
      4'h1:    return 1;
      4'h3:    return 2;
      default: return 4;
    endcase
  endfunction

  function automatic logic [2:0] size_for(input logic [3:0] strb);
    case (nbytes(strb))
      1:       return bus_pkg::SIZE_BYTE;
      2:       return bus_pkg::SIZE_HALF;
      default: return bus_pkg::SIZE_WORD;
    endcase
  endfunction

  // half by bit 2, right-aligned by the byte offset, masked to the access width
  function automatic logic [31:0] lane_value(input logic [63:0] dword,
                                             input logic [31:0] addr,
                                             input logic [3:0]  strb);
    logic [31:0] word;
    int          nb;
    word = addr[2] ? dword[63:32] : dword[31:0];
    word = word >> (8 * int'(addr[1:0]));
    nb = nbytes(strb);
    if (nb < 4)
    begin
      word = word & ((32'd1 << (8 * nb)) - 32'd1);
    end
    return word;
  endfunction

  task automatic compare(input string name, input int num, input logic [31:0] expv,
                         input logic [31:0] act);
    if (expv !== act)
    begin
      $display("Mismatch %s #%0d expected %h actual %h", name, num, expv, act);
      ok = 0;
    end
  endtask

  task automatic finish_test(input string name, input logic [31:0] addr);
    tests++;
    if (ok)
    begin
      passes++;
      $display("pass %s #%0d addr %h", name, tests, addr);
    end
    else
    begin
      errors++;
      $display("fail %s #%0d addr %h", name, tests, addr);
    end
  endtask

  task automatic close_report(input int assert_fails);
    if (ar_cnt != fetches + axi_loads)
    begin
      $display("%0d AXI reads issued for %0d bus reads", ar_cnt, fetches + axi_loads);
      errors++;
    end
    if (aw_cnt != stores)
    begin
      $display("%0d AXI writes issued for %0d stores", aw_cnt, stores);
      errors++;
    end
    if (assert_fails != 0)
    begin
      $display("%0d bus protocol assertions failed", assert_fails);
      errors += assert_fails;
    end
    $display("tests %0d, passed %0d, errors %0d", tests, passes, errors);
  endtask

  // cycle count since reset release
  always @(posedge clk)
  begin
    if (rst)
    begin
      mtime <= '0;
    end
    else
    begin
      mtime <= mtime + 64'd1;
    end
  end

  always @(posedge clk)
  begin
    if (!rst)
    begin
      if (axi_arvalid_i && axi_arready_i)
      begin
        ar_cnt++;
        ar_size_q = axi_arsize_i;
      end
      if (axi_awvalid_i && axi_awready_i)
      begin
        aw_cnt++;
        aw_size_q = axi_awsize_i;
      end
      if (axi_wvalid_i && axi_wready_i)
      begin
        wstrb_q = axi_wstrb_i;
      end

      if (ifu_rvalid_i)
      begin
        ok = 1;
        fetches++;
        exp = lane_value(shadow[ifu_araddr_i[10:3]], ifu_araddr_i, 4'hf);
        compare("fetch", tests + 1, exp, ifu_rdata_i);
        compare("fetch arsize", tests + 1, 32'(bus_pkg::SIZE_WORD), 32'(ar_size_q));
        finish_test("fetch", ifu_araddr_i);
      end

      if (lsu_rvalid_i)
      begin
        ok = 1;
        if (lsu_araddr_i == bus_pkg::MTIME_ADDR || lsu_araddr_i == bus_pkg::MTIME_ADDR_HI)
        begin
          exp = (lsu_araddr_i == bus_pkg::MTIME_ADDR_HI) ? mtime[63:32] : mtime[31:0];
          compare("clint", tests + 1, exp, lsu_rdata_i);
          finish_test("clint", lsu_araddr_i);
        end
        else
        begin
          axi_loads++;
          exp = lane_value(shadow[lsu_araddr_i[10:3]], lsu_araddr_i, lsu_rstrb_i);
          compare("load", tests + 1, exp, lsu_rdata_i);
          compare("load arsize", tests + 1, 32'(size_for(lsu_rstrb_i)), 32'(ar_size_q));
          finish_test("load", lsu_araddr_i);
        end
      end

      if (lsu_wready_i)
      begin
        ok = 1;
        stores++;
        exp_strb = {4'b0000, lsu_wstrb_i} <<
                   (int'(lsu_awaddr_i[1:0]) + 4 * int'(lsu_awaddr_i[2]));
        compare("store awsize", tests + 1, 32'(size_for(lsu_wstrb_i)), 32'(aw_size_q));
        compare("store wstrb", tests + 1, 32'(exp_strb), 32'(wstrb_q));
        for (int k = 0; k < nbytes(lsu_wstrb_i); k++)
        begin
          shadow[lsu_awaddr_i[10:3]][8 * (4 * int'(lsu_awaddr_i[2]) +
                                          int'(lsu_awaddr_i[1:0]) + k) +: 8] =
            lsu_wdata_i[8 * k +: 8];
        end
        finish_test("store", lsu_awaddr_i);
      end
    end
  end

endmodule

// File: dv/bus_checker.sv
`timescale 1ns/1ps

module bus_checker (
  input logic                           clk,
  input logic                           rst,
  input logic                           axi_arvalid_o,
  input logic                           axi_arready_i,
  input logic [bus_pkg::ADDR_W-1:0]     axi_araddr_o,
  input logic [bus_pkg::AXI_ID_W-1:0]   axi_arid_o,
  input logic [bus_pkg::AXI_LEN_W-1:0]  axi_arlen_o,
  input logic [1:0]                     axi_arburst_o,
  input logic                           axi_awvalid_o,
  input logic                           axi_awready_i,
  input logic [bus_pkg::ADDR_W-1:0]     axi_awaddr_o,
  input logic [bus_pkg::AXI_ID_W-1:0]   axi_awid_o,
  input logic [bus_pkg::AXI_LEN_W-1:0]  axi_awlen_o,
  input logic [1:0]                     axi_awburst_o,
  input logic                           axi_wvalid_o,
  input logic                           axi_wready_i,
  input logic [bus_pkg::AXI_DATA_W-1:0] axi_wdata_o,
  input logic [bus_pkg::STRB_W-1:0]     axi_wstrb_o,
  input logic                           axi_wlast_o,
  input logic                           axi_rvalid_i,
  input logic [1:0]                     axi_rresp_i,
  input logic                           axi_rready_o,
  input logic                           axi_bvalid_i,
  input logic [1:0]                     axi_bresp_i,
  input logic                           axi_bready_o,
  input logic                           ifu_rvalid_o,
  input logic                           lsu_rvalid_o,
  input logic                           lsu_wready_o
);

  int fail_cnt = 0;

  // valid and payload hold until ready
  ar_hold: assert property (@(posedge clk) disable iff (rst)
    axi_arvalid_o && !axi_arready_i |=> axi_arvalid_o && $stable(axi_araddr_o))
    else
    begin
      fail_cnt++;
      $error("arvalid or araddr changed before arready");
    end
  aw_hold: assert property (@(posedge clk) disable iff (rst)
    axi_awvalid_o && !axi_awready_i |=> axi_awvalid_o && $stable(axi_awaddr_o))
    else
    begin
      fail_cnt++;
      $error("awvalid or awaddr changed before awready");
    end
  w_hold: assert property (@(posedge clk) disable iff (rst)
    axi_wvalid_o && !axi_wready_i |=>
      axi_wvalid_o && $stable(axi_wdata_o) && $stable(axi_wstrb_o))
    else
    begin
      fail_cnt++;
      $error("wvalid, wdata or wstrb changed before wready");
    end

  one_addr: assert property (@(posedge clk) disable iff (rst)
    !(axi_arvalid_o && axi_awvalid_o))
    else
    begin
      fail_cnt++;
      $error("arvalid and awvalid high together");
    end

  // single beat, incrementing, id zero
  ar_fixed: assert property (@(posedge clk) disable iff (rst)
    axi_arvalid_o |-> axi_arid_o == 4'd0 && axi_arlen_o == 8'd0 && axi_arburst_o == 2'b01)
    else
    begin
      fail_cnt++;
      $error("read address is not a single INCR beat with id zero");
    end
  aw_fixed: assert property (@(posedge clk) disable iff (rst)
    axi_awvalid_o |-> axi_awid_o == 4'd0 && axi_awlen_o == 8'd0 && axi_awburst_o == 2'b01)
    else
    begin
      fail_cnt++;
      $error("write address is not a single INCR beat with id zero");
    end
  w_last: assert property (@(posedge clk) disable iff (rst)
    axi_wlast_o == axi_wvalid_o)
    else
    begin
      fail_cnt++;
      $error("wlast does not follow wvalid");
    end
  resp_ready: assert property (@(posedge clk) disable iff (rst)
    axi_rready_o && axi_bready_o)
    else
    begin
      fail_cnt++;
      $error("rready or bready is low");
    end

  r_okay: assert property (@(posedge clk) disable iff (rst)
    axi_rvalid_i |-> axi_rresp_i == bus_pkg::AXI_RESP_OKAY)
    else
    begin
      fail_cnt++;
      $error("read response is not OKAY");
    end
  b_okay: assert property (@(posedge clk) disable iff (rst)
    axi_bvalid_i |-> axi_bresp_i == bus_pkg::AXI_RESP_OKAY)
    else
    begin
      fail_cnt++;
      $error("write response is not OKAY");
    end

  // done pulses are single cycle
  ifu_pulse: assert property (@(posedge clk) disable iff (rst)
    ifu_rvalid_o |=> !ifu_rvalid_o)
    else
    begin
      fail_cnt++;
      $error("ifu_rvalid_o longer than one cycle");
    end
  lsu_r_pulse: assert property (@(posedge clk) disable iff (rst)
    lsu_rvalid_o |=> !lsu_rvalid_o)
    else
    begin
      fail_cnt++;
      $error("lsu_rvalid_o longer than one cycle");
    end
  lsu_w_pulse: assert property (@(posedge clk) disable iff (rst)
    lsu_wready_o |=> !lsu_wready_o)
    else
    begin
      fail_cnt++;
      $error("lsu_wready_o longer than one cycle");
    end

endmodule

bind cpu_bus_top bus_checker i_checker (.*);

// File: hw/cpu_bus_top.sv
`timescale 1ns/1ps

module cpu_bus_top (
  input  logic                           clk,
  input  logic                           rst,

  // fetch unit
  input  logic                           ifu_arvalid_i,
  input  logic [bus_pkg::ADDR_W-1:0]     ifu_araddr_i,
  output logic                           ifu_rvalid_o,
  output logic [bus_pkg::DATA_W-1:0]     ifu_rdata_o,

  // load/store unit
  input  logic                           lsu_arvalid_i,
  input  logic [bus_pkg::ADDR_W-1:0]     lsu_araddr_i,
  input  logic [bus_pkg::REQ_STRB_W-1:0] lsu_rstrb_i,
  output logic                           lsu_rvalid_o,
  output logic [bus_pkg::DATA_W-1:0]     lsu_rdata_o,
  input  logic                           lsu_awvalid_i,
  input  logic [bus_pkg::ADDR_W-1:0]     lsu_awaddr_i,
  input  logic [bus_pkg::DATA_W-1:0]     lsu_wdata_i,
  input  logic [bus_pkg::REQ_STRB_W-1:0] lsu_wstrb_i,
  output logic                           lsu_wready_o,

  // axi write address
  output logic [bus_pkg::AXI_ID_W-1:0]   axi_awid_o,
  output logic [bus_pkg::ADDR_W-1:0]     axi_awaddr_o,
  output logic [bus_pkg::AXI_LEN_W-1:0]  axi_awlen_o,
  output logic [2:0]                     axi_awsize_o,
  output logic [1:0]                     axi_awburst_o,
  output logic                           axi_awvalid_o,
  input  logic                           axi_awready_i,

  // axi write data
  output logic [bus_pkg::AXI_DATA_W-1:0] axi_wdata_o,
  output logic [bus_pkg::STRB_W-1:0]     axi_wstrb_o,
  output logic                           axi_wlast_o,
  output logic                           axi_wvalid_o,
  input  logic                           axi_wready_i,

  // axi write response
  input  logic [1:0]                     axi_bresp_i,
  input  logic                           axi_bvalid_i,
  output logic                           axi_bready_o,

  // axi read address
  output logic [bus_pkg::AXI_ID_W-1:0]   axi_arid_o,
  output logic [bus_pkg::ADDR_W-1:0]     axi_araddr_o,
  output logic [bus_pkg::AXI_LEN_W-1:0]  axi_arlen_o,
  output logic [2:0]                     axi_arsize_o,
  output logic [1:0]                     axi_arburst_o,
  output logic                           axi_arvalid_o,
  input  logic                           axi_arready_i,

  // axi read data
  input  logic [bus_pkg::AXI_DATA_W-1:0] axi_rdata_i,
  input  logic [1:0]                     axi_rresp_i,
  input  logic                           axi_rvalid_i,
  output logic                           axi_rready_o
);

  logic                       sel_lsu;
  logic                       sel_store;
  logic [bus_pkg::ADDR_W-1:0] sel_addr;
  logic                       clint_rd;
  logic [bus_pkg::DATA_W-1:0] steer_rdata;
  logic [bus_pkg::DATA_W-1:0] clint_rdata;
  logic [bus_pkg::DATA_W-1:0] rdata;

  // single-beat transfers only
  assign axi_awid_o    = bus_pkg::AXI_ID_ZERO;
  assign axi_arid_o    = bus_pkg::AXI_ID_ZERO;
  assign axi_awlen_o   = bus_pkg::AXI_LEN_SINGLE;
  assign axi_arlen_o   = bus_pkg::AXI_LEN_SINGLE;
  assign axi_awburst_o = bus_pkg::AXI_BURST_INCR;
  assign axi_arburst_o = bus_pkg::AXI_BURST_INCR;
  assign axi_wlast_o   = axi_wvalid_o;
  assign axi_rready_o  = 1'b1;
  assign axi_bready_o  = 1'b1;

  // timer data wins on a clint read
  assign rdata       = clint_rd ? clint_rdata : steer_rdata;
  assign ifu_rdata_o = rdata;
  assign lsu_rdata_o = rdata;

  bus_arbiter i_arbiter (
    .clk           (clk),
    .rst           (rst),
    .ifu_arvalid_i (ifu_arvalid_i),
    .ifu_araddr_i  (ifu_araddr_i),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_awvalid_i (lsu_awvalid_i),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .lsu_wready_o  (lsu_wready_o),
    .axi_arvalid_o (axi_arvalid_o),
    .axi_araddr_o  (axi_araddr_o),
    .axi_arready_i (axi_arready_i),
    .axi_rvalid_i  (axi_rvalid_i),
    .axi_awvalid_o (axi_awvalid_o),
    .axi_awaddr_o  (axi_awaddr_o),
    .axi_awready_i (axi_awready_i),
    .axi_wvalid_o  (axi_wvalid_o),
    .axi_wready_i  (axi_wready_i),
    .axi_bvalid_i  (axi_bvalid_i),
    .sel_lsu_o     (sel_lsu),
    .sel_store_o   (sel_store),
    .sel_addr_o    (sel_addr),
    .clint_rd_o    (clint_rd)
  );

  lane_steer i_lane_steer (
    .sel_addr_i   (sel_addr),
    .sel_lsu_i    (sel_lsu),
    .sel_store_i  (sel_store),
    .lsu_rstrb_i  (lsu_rstrb_i),
    .lsu_wstrb_i  (lsu_wstrb_i),
    .lsu_wdata_i  (lsu_wdata_i),
    .axi_rdata_i  (axi_rdata_i),
    .axi_arsize_o (axi_arsize_o),
    .axi_awsize_o (axi_awsize_o),
    .axi_wdata_o  (axi_wdata_o),
    .axi_wstrb_o  (axi_wstrb_o),
    .rdata_o      (steer_rdata)
  );

  clint_timer i_clint_timer (
    .clk       (clk),
    .rst       (rst),
    .rd_i      (clint_rd),
    .rd_addr_i (sel_addr),
    .rd_data_o (clint_rdata)
  );

endmodule

// File: hw/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                       clk,
  input  logic                       rst,

  // fetch unit
  input  logic                       ifu_arvalid_i,
  input  logic [bus_pkg::ADDR_W-1:0] ifu_araddr_i,
  output logic                       ifu_rvalid_o,

  // load/store unit
  input  logic                       lsu_arvalid_i,
  input  logic [bus_pkg::ADDR_W-1:0] lsu_araddr_i,
  input  logic                       lsu_awvalid_i,
  input  logic [bus_pkg::ADDR_W-1:0] lsu_awaddr_i,
  output logic                       lsu_rvalid_o,
  output logic                       lsu_wready_o,

  // axi handshakes
  output logic                       axi_arvalid_o,
  output logic [bus_pkg::ADDR_W-1:0] axi_araddr_o,
  input  logic                       axi_arready_i,
  input  logic                       axi_rvalid_i,
  output logic                       axi_awvalid_o,
  output logic [bus_pkg::ADDR_W-1:0] axi_awaddr_o,
  input  logic                       axi_awready_i,
  output logic                       axi_wvalid_o,
  input  logic                       axi_wready_i,
  input  logic                       axi_bvalid_i,

  // to lane steering and timer
  output logic                       sel_lsu_o,
  output logic                       sel_store_o,
  output logic [bus_pkg::ADDR_W-1:0] sel_addr_o,
  output logic                       clint_rd_o
);

  bus_pkg::arb_state_e state_q;
  bus_pkg::arb_state_e state_d;
  logic                w_done_q;
  logic                ar_hold_q;
  logic                lsu_req;
  logic                lsu_store;
  logic                clint_hit;
  logic                if_go;

  assign lsu_req   = lsu_arvalid_i | lsu_awvalid_i;
  assign lsu_store = lsu_awvalid_i;

  // timer words never reach the bus
  assign clint_hit = lsu_arvalid_i &
                     ((lsu_araddr_i == bus_pkg::MTIME_ADDR) |
                      (lsu_araddr_i == bus_pkg::MTIME_ADDR_HI));

  // lsu wins unless a fetch arvalid is already out and waiting for arready
  assign if_go = ifu_arvalid_i & (ar_hold_q | ~lsu_req);

  // address and lane selection
  assign sel_lsu_o   = (state_q == bus_pkg::LS_ADDR) | (state_q == bus_pkg::LS_DATA);
  assign sel_store_o = sel_lsu_o & lsu_store;
  assign sel_addr_o  = !sel_lsu_o ? ifu_araddr_i :
                       lsu_store  ? lsu_awaddr_i : lsu_araddr_i;

  assign axi_araddr_o = sel_addr_o;
  assign axi_awaddr_o = sel_addr_o;

  // each valid only in its own state
  assign axi_arvalid_o = ((state_q == bus_pkg::IF_ADDR) & if_go) |
                         ((state_q == bus_pkg::LS_ADDR) & lsu_arvalid_i & ~clint_hit);
  assign axi_awvalid_o = (state_q == bus_pkg::LS_ADDR) & lsu_awvalid_i;
  assign axi_wvalid_o  = (state_q == bus_pkg::LS_DATA) & lsu_store & ~w_done_q;

  assign clint_rd_o = (state_q == bus_pkg::LS_ADDR) & clint_hit;

  // done pulses
  assign ifu_rvalid_o = (state_q == bus_pkg::IF_DATA) & axi_rvalid_i;
  assign lsu_rvalid_o = clint_rd_o |
                        ((state_q == bus_pkg::LS_DATA) & ~lsu_store & axi_rvalid_i);
  assign lsu_wready_o = (state_q == bus_pkg::LS_DATA) & lsu_store & w_done_q & axi_bvalid_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      bus_pkg::IF_ADDR:
      begin
        if (if_go & axi_arready_i)
        begin
          state_d = bus_pkg::IF_DATA;
        end
        else if (lsu_req & ~ar_hold_q)
        begin
          state_d = bus_pkg::LS_ADDR;
        end
      end
      bus_pkg::IF_DATA:
      begin
        if (axi_rvalid_i)
        begin
          state_d = bus_pkg::IF_ADDR;
        end
      end
      bus_pkg::LS_ADDR:
      begin
        if (clint_hit)
        begin
          state_d = bus_pkg::IF_ADDR;
        end
        else if ((axi_arvalid_o & axi_arready_i) | (axi_awvalid_o & axi_awready_i))
        begin
          state_d = bus_pkg::LS_DATA;
        end
      end
      bus_pkg::LS_DATA:
      begin
        if (lsu_rvalid_o | lsu_wready_o)
        begin
          state_d = bus_pkg::IF_ADDR;
        end
      end
      default:
      begin
        state_d = bus_pkg::IF_ADDR;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= bus_pkg::IF_ADDR;
      w_done_q  <= 1'b0;
      ar_hold_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // fetch address presented but not yet taken
      ar_hold_q <= (state_q == bus_pkg::IF_ADDR) & axi_arvalid_o & ~axi_arready_i;
      if (lsu_wready_o)
      begin
        w_done_q <= 1'b0;
      end
      else if (axi_wvalid_o & axi_wready_i)
      begin
        w_done_q <= 1'b1;
      end
    end
  end

endmodule

// File: hw/clint_timer.sv
`timescale 1ns/1ps

module clint_timer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       rd_i,
  input  logic [bus_pkg::ADDR_W-1:0] rd_addr_i,
  output logic [bus_pkg::DATA_W-1:0] rd_data_o
);

  logic [63:0] mtime_q;

  // free running, one tick per clock
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q <= '0;
    end
    else
    begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  // answered in the same cycle as the read strobe
  assign rd_data_o = !rd_i                                ? '0 :
                     (rd_addr_i == bus_pkg::MTIME_ADDR_HI) ? mtime_q[63:32] :
                                                             mtime_q[31:0];

endmodule

// File: hw/lane_steer.sv
`timescale 1ns/1ps

module lane_steer (
  input  logic [bus_pkg::ADDR_W-1:0]     sel_addr_i,
  input  logic                           sel_lsu_i,
  input  logic                           sel_store_i,
  input  logic [bus_pkg::REQ_STRB_W-1:0] lsu_rstrb_i,
  input  logic [bus_pkg::REQ_STRB_W-1:0] lsu_wstrb_i,
  input  logic [bus_pkg::DATA_W-1:0]     lsu_wdata_i,
  input  logic [bus_pkg::AXI_DATA_W-1:0] axi_rdata_i,
  output bus_pkg::axi_size_e             axi_arsize_o,
  output bus_pkg::axi_size_e             axi_awsize_o,
  output logic [bus_pkg::AXI_DATA_W-1:0] axi_wdata_o,
  output logic [bus_pkg::STRB_W-1:0]     axi_wstrb_o,
  output logic [bus_pkg::DATA_W-1:0]     rdata_o
);

  logic [1:0]                     byte_off;
  logic [bus_pkg::REQ_STRB_W-1:0] rd_strb;
  logic [bus_pkg::DATA_W-1:0]     rd_half;
  logic [bus_pkg::DATA_W-1:0]     rd_shifted;
  logic [bus_pkg::DATA_W-1:0]     rd_mask;
  logic [bus_pkg::DATA_W-1:0]     wr_data;
  logic [bus_pkg::REQ_STRB_W-1:0] wr_lane;

  // unknown strobe patterns fall back to a full word
  function automatic bus_pkg::axi_size_e size_of(input logic [bus_pkg::REQ_STRB_W-1:0] strb);
    case (strb)
      4'h1:    return bus_pkg::SIZE_BYTE;
      4'h3:    return bus_pkg::SIZE_HALF;
      default: return bus_pkg::SIZE_WORD;
    endcase
  endfunction

  assign byte_off = sel_addr_i[1:0];

  // fetches always read a whole word
  assign rd_strb      = sel_lsu_i ? lsu_rstrb_i : 4'hf;
  assign axi_arsize_o = size_of(rd_strb);
  assign axi_awsize_o = size_of(lsu_wstrb_i);

  // read path: pick half, right-align, then mask to access width
  assign rd_half    = sel_addr_i[2] ? axi_rdata_i[63:32] : axi_rdata_i[31:0];
  assign rd_shifted = rd_half >> {byte_off, 3'b000};
  assign rd_mask    = {{8{rd_strb[3]}}, {8{rd_strb[2]}}, {8{rd_strb[1]}}, {8{rd_strb[0]}}};
  assign rdata_o    = rd_shifted & rd_mask;

  // write path
  assign wr_data = lsu_wdata_i << {byte_off, 3'b000};
  assign wr_lane = lsu_wstrb_i << byte_off;

  // same word on both halves, strobes pick the live one
  assign axi_wdata_o = {wr_data, wr_data};
  assign axi_wstrb_o = !sel_store_i   ? '0 :
                       sel_addr_i[2]  ? {wr_lane, 4'b0000} : {4'b0000, wr_lane};

endmodule

// File: hw/bus_pkg.sv
package bus_pkg;

  // requester side
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int REQ_STRB_W = 4;

  // axi master side
  localparam int AXI_DATA_W = 64;
  localparam int STRB_W = 8;
  localparam int AXI_ID_W = 4;
  localparam int AXI_LEN_W = 8;

  // single beat, incrementing, id zero
  localparam logic [AXI_LEN_W-1:0] AXI_LEN_SINGLE = 8'd0;
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  localparam logic [AXI_ID_W-1:0] AXI_ID_ZERO = 4'd0;
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // machine timer words, answered inside the front end
  localparam logic [ADDR_W-1:0] MTIME_ADDR = 32'h0200_bff8;
  localparam logic [ADDR_W-1:0] MTIME_ADDR_HI = 32'h0200_bffc;

  // arbiter states
  // IF_* serve the fetch unit, LS_* serve loads and stores
  typedef enum logic [1:0] {
    IF_ADDR = 2'd0,
    IF_DATA = 2'd1,
    LS_ADDR = 2'd2,
    LS_DATA = 2'd3
  } arb_state_e;

  // axsize encoding, bytes per beat as log2
  typedef enum logic [2:0] {
    SIZE_BYTE = 3'd0,
    SIZE_HALF = 3'd1,
    SIZE_WORD = 3'd2
  } axi_size_e;

endpackage
